// File: Makefile
# Verilator build and run for the SIMD result staging wrapper
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= simd_result_wrapper_tb
FILELIST  ?= simd_result_wrapper.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

# Sources come from the file list, plus the included configuration header
SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/simd_result_cfg.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail is taken from the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/result_fifo.sv
// Pipelined result FIFO
// Circular buffer with the head word held in an output register
// Raises almost_full once the entry count reaches DEPTH minus THRESHOLD

`timescale 1ns/1ps
`default_nettype none

module result_fifo #(
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = 1,
  parameter int WIDTH     = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             write,
  input  logic [WIDTH-1:0] write_data,
  input  logic             pipe_read,
  output logic             pipe_valid,
  output logic [WIDTH-1:0] pipe_data,
  output logic             almost_full
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [CW-1:0] AF_LEVEL = CW'(DEPTH - THRESHOLD);

  // Storage and pointers
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic [PW-1:0]    rd_ptr_nxt;

  // Entries held, head included
  logic [CW-1:0]    count;
  // Entries left after this cycle's pop, ignoring this cycle's write
  logic [CW-1:0]    count_kept;
  logic             pop;

  // Wrap a pointer at DEPTH
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    if (ptr == PW'(DEPTH - 1))
      return '0;
    return ptr + PW'(1);
  endfunction

  // ------------------------------------------------
  // Pointer and count update
  // ------------------------------------------------

  // A read only counts when the head is valid
  assign pop        = pipe_read & pipe_valid;
  assign rd_ptr_nxt = pop ? ptr_inc(rd_ptr) : rd_ptr;
  assign count_kept = count - CW'(pop);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (write)
        wr_ptr <= ptr_inc(wr_ptr);
      rd_ptr <= rd_ptr_nxt;
      count  <= count_kept + CW'(write);
    end
  end

  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_ptr] <= write_data;
  end

  // ------------------------------------------------
  // Head register
  // ------------------------------------------------

  // Head follows the oldest entry already in storage
  // A word written this edge shows up one edge later
  always_ff @(posedge clk)
  begin
    if (rst)
      pipe_valid <= 1'b0;
    else
      pipe_valid <= (count_kept != '0);
  end

  always_ff @(posedge clk)
  begin
    pipe_data <= mem[rd_ptr_nxt];
  end

  // Flow control straight from the count flops
  assign almost_full = (count >= AF_LEVEL);

endmodule

`default_nettype wire

// File: hw/result_queue.sv
// SIMD result queue
// One FIFO per execution lane plus a tag FIFO
// Flags a complete result set when the tag and every lane head are valid

`timescale 1ns/1ps
`default_nettype none

`include "simd_result_cfg.svh"

module result_queue (
  input  logic                         clk,
  input  logic                         rst,
  input  simd_result_pkg::lane_mask_t  lane_valid,
  input  simd_result_pkg::lanes_data_t lane_data,
  output simd_result_pkg::lane_mask_t  lane_ready,
  input  logic                         tag_valid,
  input  simd_result_pkg::op_tag_t     tag,
  output logic                         tag_ready,
  input  logic                         pop,
  output logic                         set_ready,
  output simd_result_pkg::op_tag_t     head_tag,
  output simd_result_pkg::lanes_data_t head_regs
);

  // Head valid of each lane FIFO
  simd_result_pkg::lane_mask_t lane_head_valid;
  logic tag_head_valid;
  logic tag_almost_full;

  // ------------------------------------------------
  // Lane FIFOs
  // ------------------------------------------------

  // Each lane is written on its own strobe
  // All lanes are read together on pop
  genvar lane;
  generate
    for (lane = 0; lane < `SIMD_NUM_LANES; lane++)
    begin : g_lane_fifo
      logic almost_full;

      result_fifo #(
        .DEPTH     (`SIMD_LANE_FIFO_DEPTH),
        .THRESHOLD (`SIMD_LANE_FIFO_THRESHOLD),
        .WIDTH     (`SIMD_LANE_WIDTH)
      ) u_lane_fifo (
        .clk         (clk),
        .rst         (rst),
        .write       (lane_valid[lane]),
        .write_data  (lane_data[lane*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH]),
        .pipe_read   (pop),
        .pipe_valid  (lane_head_valid[lane]),
        .pipe_data   (head_regs[lane*`SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH]),
        .almost_full (almost_full)
      );

      // Combinational ready from the lane count
      assign lane_ready[lane] = ~almost_full;
    end
  endgenerate

  // ------------------------------------------------
  // Tag FIFO
  // ------------------------------------------------

  result_fifo #(
    .DEPTH     (`SIMD_TAG_FIFO_DEPTH),
    .THRESHOLD (`SIMD_TAG_FIFO_THRESHOLD),
    .WIDTH     (`SIMD_TAG_WIDTH)
  ) u_tag_fifo (
    .clk         (clk),
    .rst         (rst),
    .write       (tag_valid),
    .write_data  (tag),
    .pipe_read   (pop),
    .pipe_valid  (tag_head_valid),
    .pipe_data   (head_tag),
    .almost_full (tag_almost_full)
  );

  // Tag ready lags the fill by one cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      tag_ready <= 1'b0;
    else
      tag_ready <= ~tag_almost_full;
  end

  // Whole set present at the heads
  assign set_ready = tag_head_valid & (&lane_head_valid);

endmodule

`default_nettype wire

// File: hw/simd_result_cfg.svh
// SIMD result staging configuration
// Lane geometry, tag width and FIFO sizing shared by the package and the RTL

`ifndef SIMD_RESULT_CFG_SVH
`define SIMD_RESULT_CFG_SVH

// ------------------------------------------------
// Execution lanes
// ------------------------------------------------

// Number of execution lanes in the PE
`define SIMD_NUM_LANES 4

// Bits per lane result word
`define SIMD_LANE_WIDTH 16

// Operation tag from the PE controller
`define SIMD_TAG_WIDTH 8

// ------------------------------------------------
// Staging FIFOs
// ------------------------------------------------

// Per-lane result FIFO
`define SIMD_LANE_FIFO_DEPTH 4
`define SIMD_LANE_FIFO_THRESHOLD 1

// Tag FIFO, threshold covers the registered tag ready
`define SIMD_TAG_FIFO_DEPTH 4
`define SIMD_TAG_FIFO_THRESHOLD 1

`endif

// File: hw/simd_result_pkg.sv
// SIMD result staging types
// Lane words, packed lane vectors, lane masks, tags and upstream FSM states

`default_nettype none

`include "simd_result_cfg.svh"

package simd_result_pkg;

  // One lane result word
  typedef logic [`SIMD_LANE_WIDTH-1:0] lane_data_t;

  // All lane words packed, lane 0 in the low bits
  typedef logic [`SIMD_NUM_LANES*`SIMD_LANE_WIDTH-1:0] lanes_data_t;

  // One bit per execution lane
  typedef logic [`SIMD_NUM_LANES-1:0] lane_mask_t;

  // Operation tag carried with each result set
  typedef logic [`SIMD_TAG_WIDTH-1:0] op_tag_t;

  // Upstream transfer FSM
  typedef enum logic [2:0] {
    WAIT,
    SEND_DATA,
    WAIT_FOR_COMPLETE,
    WAIT_COMPLETE_DEASSERTED,
    COMPLETE
  } upstream_state_t;

endpackage

`default_nettype wire

// File: hw/simd_result_wrapper.sv
// SIMD result staging wrapper
// Queues per-lane results and operation tags
// and hands complete tagged sets to the stack upstream interface

`timescale 1ns/1ps
`default_nettype none

module simd_result_wrapper (
  input  logic                         clk,
  input  logic                         rst,

  // Results from the streaming controller
  input  simd_result_pkg::lane_mask_t  lane_valid,
  input  simd_result_pkg::lanes_data_t lane_data,
  output simd_result_pkg::lane_mask_t  lane_ready,

  // Tags from the PE controller
  input  logic                         tag_valid,
  input  simd_result_pkg::op_tag_t     tag,
  output logic                         tag_ready,

  // Stack upstream interface
  output simd_result_pkg::op_tag_t     up_tag,
  output simd_result_pkg::lanes_data_t up_regs,
  output simd_result_pkg::lane_mask_t  up_regs_valid,
  input  logic                         up_ready,
  input  logic                         up_complete
);

  // Full set waiting at the FIFO heads
  logic set_ready;
  // Read strobe for all FIFOs together
  logic pop;

  // ------------------------------------------------
  // Result and tag staging
  // ------------------------------------------------

  // Heads go straight out as the upstream tag and registers
  result_queue u_result_queue (
    .clk        (clk),
    .rst        (rst),
    .lane_valid (lane_valid),
    .lane_data  (lane_data),
    .lane_ready (lane_ready),
    .tag_valid  (tag_valid),
    .tag        (tag),
    .tag_ready  (tag_ready),
    .pop        (pop),
    .set_ready  (set_ready),
    .head_tag   (up_tag),
    .head_regs  (up_regs)
  );

  // ------------------------------------------------
  // Upstream handshake
  // ------------------------------------------------

  upstream_cntl u_upstream_cntl (
    .clk           (clk),
    .rst           (rst),
    .set_ready     (set_ready),
    .up_ready      (up_ready),
    .up_complete   (up_complete),
    .pop           (pop),
    .up_regs_valid (up_regs_valid)
  );

endmodule

`default_nettype wire

// File: hw/upstream_cntl.sv
// Upstream transfer control
// Presents one tagged result set to the stack upstream interface
// then waits for the complete handshake to rise and fall

`timescale 1ns/1ps
`default_nettype none

module upstream_cntl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        set_ready,
  input  logic                        up_ready,
  input  logic                        up_complete,
  output logic                        pop,
  output simd_result_pkg::lane_mask_t up_regs_valid
);

  // Registered upstream handshake inputs
  logic up_ready_q;
  logic up_complete_q;

  simd_result_pkg::upstream_state_t state;
  simd_result_pkg::upstream_state_t state_nxt;

  // High in the single transfer cycle
  logic send_cycle;

  // ------------------------------------------------
  // Input and state registers
  // ------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      up_ready_q    <= 1'b0;
      up_complete_q <= 1'b0;
      state         <= simd_result_pkg::WAIT;
    end
    else
    begin
      up_ready_q    <= up_ready;
      up_complete_q <= up_complete;
      state         <= state_nxt;
    end
  end

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------

  always_comb
  begin
    state_nxt = simd_result_pkg::WAIT;
    case (state)
      // Full set queued and upstream able to take it
      simd_result_pkg::WAIT:
        if (set_ready && up_ready_q)
          state_nxt = simd_result_pkg::SEND_DATA;
        else
          state_nxt = simd_result_pkg::WAIT;

      // One cycle of valid, heads popped here
      simd_result_pkg::SEND_DATA:
        state_nxt = simd_result_pkg::WAIT_FOR_COMPLETE;

      // Upstream has the set once complete rises
      simd_result_pkg::WAIT_FOR_COMPLETE:
        if (up_complete_q)
          state_nxt = simd_result_pkg::WAIT_COMPLETE_DEASSERTED;
        else
          state_nxt = simd_result_pkg::WAIT_FOR_COMPLETE;

      // Complete must drop before the next set
      simd_result_pkg::WAIT_COMPLETE_DEASSERTED:
        if (up_complete_q)
          state_nxt = simd_result_pkg::WAIT_COMPLETE_DEASSERTED;
        else
          state_nxt = simd_result_pkg::COMPLETE;

      simd_result_pkg::COMPLETE:
        state_nxt = simd_result_pkg::WAIT;

      // Unknown encodings recover to idle
      default:
        state_nxt = simd_result_pkg::WAIT;
    endcase
  end

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------

  assign send_cycle = (state == simd_result_pkg::SEND_DATA);

  // Pop every FIFO and flag every lane in the same cycle
  assign pop           = send_cycle;
  assign up_regs_valid = {$bits(simd_result_pkg::lane_mask_t){send_cycle}};

endmodule

`default_nettype wire

// File: simd_result_wrapper.f
+incdir+hw
hw/simd_result_pkg.sv
hw/result_fifo.sv
hw/result_queue.sv
hw/upstream_cntl.sv
hw/simd_result_wrapper.sv
tb/tb_clk_gen.sv
tb/simd_result_wrapper_chk.sv
tb/simd_result_wrapper_tb.sv

// File: tb/simd_result_wrapper_chk.sv
// Assertions for the SIMD result staging path
// Bound once into the upstream FSM and once into the result queue

`timescale 1ns/1ps
`default_nettype none

module simd_result_wrapper_chk (
  input logic                            clk,
  input logic                            rst,
  input simd_result_pkg::lane_mask_t     up_regs_valid,
  input simd_result_pkg::upstream_state_t state,
  input simd_result_pkg::lane_mask_t     lane_valid,
  input simd_result_pkg::lane_mask_t     lane_ready
);

  // ------------------------------------------------
  // Upstream valid
  // ------------------------------------------------

  // Valid is a single-cycle pulse
  a_valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
    up_regs_valid[0] |=> !up_regs_valid[0])
    else $error("up_regs_valid held for more than one cycle");

  // Every lane flagged together
  a_valid_lanes_equal: assert property (@(posedge clk) disable iff (rst)
    (up_regs_valid == '0) || (up_regs_valid == '1))
    else $error("up_regs_valid bits differ");

  // Only the WAIT to SEND_DATA step starts a transfer
  a_valid_from_wait: assert property (@(posedge clk) disable iff (rst)
    $rose(up_regs_valid[0]) |->
      (state == simd_result_pkg::SEND_DATA) && ($past(state) == simd_result_pkg::WAIT))
    else $error("up_regs_valid rose outside WAIT to SEND_DATA");

  // ------------------------------------------------
  // Lane inputs
  // ------------------------------------------------

  // No lane strobe against a low ready
  a_lane_write_ready: assert property (@(posedge clk) disable iff (rst)
    (lane_valid & ~lane_ready) == '0)
    else $error("lane written while its ready was low");

endmodule

// FSM instance, lane ports idle
bind upstream_cntl simd_result_wrapper_chk u_fsm_chk (
  .clk           (clk),
  .rst           (rst),
  .up_regs_valid (up_regs_valid),
  .state         (state),
  .lane_valid    ('0),
  .lane_ready    ('1)
);

// Queue instance, upstream ports idle
bind result_queue simd_result_wrapper_chk u_lane_chk (
  .clk           (clk),
  .rst           (rst),
  .up_regs_valid ('0),
  .state         (simd_result_pkg::WAIT),
  .lane_valid    (lane_valid),
  .lane_ready    (lane_ready)
);

`default_nettype wire

// File: tb/simd_result_wrapper_tb.sv
// Testbench for the SIMD result staging wrapper
// Table-driven lane and tag writes with skew, an upstream responder model,
// in-order checks of every delivered set and a back-pressure phase

`timescale 1ns/1ps
`default_nettype none

`include "simd_result_cfg.svh"

module simd_result_wrapper_tb;

  localparam int NUM_LANES       = `SIMD_NUM_LANES;
  localparam int LANE_W          = `SIMD_LANE_WIDTH;
  localparam int READY_LEVEL     = `SIMD_LANE_FIFO_DEPTH - `SIMD_LANE_FIFO_THRESHOLD;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_ENTRIES     = 10;
  localparam int NUM_BP          = 3;
  localparam int MAX_SKEW        = 4;
  localparam int WORST_HANDSHAKE = 24;
  localparam int TIMEOUT_CYCLES  =
    2 * (RESET_CYCLES + 20 + NUM_ENTRIES * (MAX_SKEW + WORST_HANDSHAKE));
  localparam simd_result_pkg::lane_mask_t ALL_LANES = '1;

  logic                         clk;
  logic                         rst;
  simd_result_pkg::lane_mask_t  lane_valid;
  simd_result_pkg::lanes_data_t lane_data;
  simd_result_pkg::lane_mask_t  lane_ready;
  logic                         tag_valid;
  simd_result_pkg::op_tag_t     tag;
  logic                         tag_ready;
  simd_result_pkg::op_tag_t     up_tag;
  simd_result_pkg::lanes_data_t up_regs;
  simd_result_pkg::lane_mask_t  up_regs_valid;
  logic                         up_ready;
  logic                         up_complete;

  // ------------------------------------------------
  // Stimulus table
  // ------------------------------------------------

  // Tag and write cycle of each lane in two bits per lane with lane 0 lowest
  // Last NUM_BP entries go in while up_ready is held low
  simd_result_pkg::op_tag_t tbl_tag [NUM_ENTRIES] = '{
    8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77, 8'hb1, 8'hb2, 8'hb3
  };
  logic [7:0] tbl_skew [NUM_ENTRIES] = '{
    8'h00, 8'he4, 8'h1b, 8'hc0, 8'h03, 8'h00, 8'h39, 8'h00, 8'h93, 8'h4e
  };
  // Expected lane words filled from the LCG
  simd_result_pkg::lanes_data_t tbl_regs [NUM_ENTRIES];

  // Entries fully written and not yet delivered
  int exp_q [$];

  logic [31:0] lcg_state      = 32'h35b30719;
  int          num_errors     = 0;
  int          num_checks     = 0;
  int          delivered      = 0;
  int          cycle_count    = 0;
  logic        handshake_open = 1'b0;
  logic        bp_hold        = 1'b0;
  int          resp_phase     = 0;
  int          resp_wait      = 0;

  tb_clk_gen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  simd_result_wrapper u_simd_result_wrapper (
    .clk           (clk),
    .rst           (rst),
    .lane_valid    (lane_valid),
    .lane_data     (lane_data),
    .lane_ready    (lane_ready),
    .tag_valid     (tag_valid),
    .tag           (tag),
    .tag_ready     (tag_ready),
    .up_tag        (up_tag),
    .up_regs       (up_regs),
    .up_regs_valid (up_regs_valid),
    .up_ready      (up_ready),
    .up_complete   (up_complete)
  );

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    num_checks++;
    if (actual !== expected)
    begin
      num_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    num_errors++;
    $display("ERROR: %s", what);
  endtask

  // Latest write cycle of any lane in an entry
  function automatic int max_skew(input int idx);
    int m;
    int l;
    m = 0;
    for (l = 0; l < NUM_LANES; l++)
      if (int'(tbl_skew[idx][2*l +: 2]) > m)
        m = int'(tbl_skew[idx][2*l +: 2]);
    return m;
  endfunction

  // Starts on a falling edge and returns on the one after the last write
  task automatic write_entry(input int idx);
    int last;
    int c;
    int l;
    simd_result_pkg::lane_mask_t strobe;
    last = max_skew(idx);
    while (!(lane_ready == ALL_LANES && tag_ready))
      @(negedge clk);
    for (c = 0; c <= last; c++)
    begin
      strobe = '0;
      for (l = 0; l < NUM_LANES; l++)
        if (int'(tbl_skew[idx][2*l +: 2]) == c)
          strobe[l] = 1'b1;
      lane_valid = strobe;
      lane_data  = tbl_regs[idx];
      tag_valid  = (c == 0);
      tag        = tbl_tag[idx];
      // Set is complete once its last lane is strobed
      if (c == last)
        exp_q.push_back(idx);
      @(negedge clk);
    end
    lane_valid = '0;
    tag_valid  = 1'b0;
  endtask

  task automatic wait_drained(input int count);
    while (delivered < count || handshake_open)
      @(negedge clk);
  endtask

  // Checks every pulse and answers it with a complete handshake
  task automatic watch_upstream();
    int idx;
    forever
    begin
      @(negedge clk);
      if (up_regs_valid != '0)
      begin
        check_equal("up_regs_valid lanes", 64'(ALL_LANES), 64'(up_regs_valid));
        if (handshake_open)
          report_failure("up_regs_valid rose before up_complete rose and fell");
        if (bp_hold)
          report_failure("up_regs_valid rose while up_ready was held low");
        if (exp_q.size() == 0)
          report_failure("up_regs_valid rose with no fully written set queued");
        else
        begin
          idx = exp_q.pop_front();
          check_equal($sformatf("entry %0d tag", idx), 64'(tbl_tag[idx]), 64'(up_tag));
          check_equal($sformatf("entry %0d lanes", idx), 64'(tbl_regs[idx]), 64'(up_regs));
          delivered++;
        end
        handshake_open = 1'b1;
        resp_wait      = 1 + int'(lcg_next() >> 30);
        resp_phase     = 1;
      end
      else if (resp_phase == 1)
      begin
        if (resp_wait > 0)
          resp_wait--;
        else
        begin
          up_complete = 1'b1;
          resp_wait   = int'(lcg_next() >> 30);
          resp_phase  = 2;
        end
      end
      else if (resp_phase == 2)
      begin
        if (resp_wait > 0)
          resp_wait--;
        else
        begin
          up_complete    = 1'b0;
          handshake_open = 1'b0;
          resp_phase     = 0;
        end
      end
    end
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial
  begin : main_seq
    int i;
    int k;
    logic [31:0] rnd;
    lane_valid  = '0;
    lane_data   = '0;
    tag_valid   = 1'b0;
    tag         = '0;
    up_ready    = 1'b1;
    up_complete = 1'b0;

    for (i = 0; i < NUM_ENTRIES; i++)
      for (k = 0; k < NUM_LANES; k++)
      begin
        rnd = lcg_next();
        tbl_regs[i][k*LANE_W +: LANE_W] = rnd[31 -: LANE_W];
      end

    // Reset values
    @(negedge clk);
    while (rst)
    begin
      check_equal("reset up_regs_valid", 64'd0, 64'(up_regs_valid));
      check_equal("reset lane_ready", 64'(ALL_LANES), 64'(lane_ready));
      @(negedge clk);
    end
    check_equal("post reset up_regs_valid", 64'd0, 64'(up_regs_valid));
    check_equal("post reset lane_ready", 64'(ALL_LANES), 64'(lane_ready));
    @(negedge clk);
    check_equal("post reset tag_ready", 64'd1, 64'(tag_ready));

    fork
      watch_upstream();
    join_none

    // Skewed sets with the responder running
    for (i = 0; i < NUM_ENTRIES - NUM_BP; i++)
      write_entry(i);
    wait_drained(NUM_ENTRIES - NUM_BP);

    // Back-pressure writes wait until the registered up_ready is low
    up_ready = 1'b0;
    repeat (2) @(negedge clk);
    bp_hold = 1'b1;
    for (k = 1; k <= NUM_BP; k++)
    begin
      write_entry(NUM_ENTRIES - NUM_BP + k - 1);
      check_equal($sformatf("lane_ready after %0d queued", k),
                  (k < READY_LEVEL) ? 64'(ALL_LANES) : 64'd0, 64'(lane_ready));
    end
    repeat (8) @(negedge clk);
    bp_hold  = 1'b0;
    up_ready = 1'b1;
    wait_drained(NUM_ENTRIES);

    // Every FIFO is empty again once the last set has gone out
    @(negedge clk);
    check_equal("drained lane_ready", 64'(ALL_LANES), 64'(lane_ready));
    check_equal("drained tag_ready", 64'd1, 64'(tag_ready));

    $display("Summary: %0d checks, %0d errors", num_checks, num_errors);
    if (num_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Run limit from table length and worst handshake
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("ERROR: timeout after %0d cycles, %0d of %0d sets delivered, %0d errors",
               cycle_count, delivered, NUM_ENTRIES, num_errors);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock, synchronous reset held for a fixed number of cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset drops on a falling edge, after all readers of that edge
  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire
